// File: compile.f
+incdir+tb
rtl/roce_qp_pkg.sv
rtl/qp_read_delay.sv
rtl/qp_cmd_decode.sv
rtl/qp_context_store.sv
rtl/qp_ack_tracker.sv
rtl/roce_qp_top.sv
tb/roce_qp_tb.sv

// File: rtl/qp_ack_tracker.sv
`timescale 1ns/1ps

module qp_ack_tracker (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        rx_valid,
  input  logic [7:0]                  rx_op_code,
  input  roce_qp_pkg::qpn_t           rx_dest_qp,
  input  roce_qp_pkg::psn_t           rx_psn,
  input  roce_qp_pkg::aeth_syndrome_t rx_syndrome,
  input  logic                        active,
  input  roce_qp_pkg::qp_idx_t        active_idx,
  input  logic                        activate,
  input  roce_qp_pkg::psn_t           start_psn,
  input  logic                        rd_valid,
  input  roce_qp_pkg::qp_idx_t        rd_idx,
  output roce_qp_pkg::psn_t           rd_acked_psn,
  output roce_qp_pkg::psn_t           last_acked_psn,
  output roce_qp_pkg::psn_t           last_nacked_psn,
  output logic                        stop_transfer
);

  roce_qp_pkg::psn_t    acked_mem [roce_qp_pkg::QP_COUNT];
  roce_qp_pkg::qp_idx_t rx_idx;
  logic                 rx_hit;
  logic                 good_ack;
  logic                 rx_active;

  assign rx_idx    = roce_qp_pkg::qpn_to_idx(rx_dest_qp);
  assign rx_hit    = rx_valid && (rx_op_code == roce_qp_pkg::RC_ACK_OPCODE) &&
                     roce_qp_pkg::qpn_in_range(rx_dest_qp);
  assign good_ack  = rx_syndrome[6:5] == 2'b00;
  assign rx_active = rx_hit && active && (rx_idx == active_idx);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < roce_qp_pkg::QP_COUNT; i++) begin
        acked_mem[i] <= '0;
      end
    end else if (rx_hit && good_ack) begin
      acked_mem[rx_idx] <= rx_psn;
    end
  end

  // Old value on a same-cycle write
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_acked_psn <= '0;
    end else if (rd_valid) begin
      rd_acked_psn <= acked_mem[rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_acked_psn  <= '0;
      last_nacked_psn <= '0;
      stop_transfer   <= 1'b0;
    end else if (activate) begin
      last_acked_psn  <= start_psn;
      last_nacked_psn <= start_psn;
      stop_transfer   <= 1'b0;
    end else if (rx_active && good_ack) begin
      last_acked_psn <= rx_psn;
      stop_transfer  <= 1'b0;
    end else if (rx_active) begin
      // Any NAK class halts the sender
      last_nacked_psn <= rx_psn;
      stop_transfer   <= 1'b1;
    end else begin
      stop_transfer <= 1'b0;
    end
  end

endmodule

// File: rtl/qp_cmd_decode.sv
`timescale 1ns/1ps

module qp_cmd_decode (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        qp_init_valid,
  input  roce_qp_pkg::qp_req_t        qp_init_req_type,
  input  roce_qp_pkg::qpn_t           qp_init_loc_qpn,
  input  logic [31:0]                 qp_init_r_key,
  input  roce_qp_pkg::qpn_t           qp_init_rem_qpn,
  input  roce_qp_pkg::psn_t           qp_init_rem_psn,
  input  roce_qp_pkg::psn_t           qp_init_loc_psn,
  input  logic [31:0]                 qp_init_rem_ip_addr,
  input  logic [63:0]                 qp_init_rem_addr,
  input  logic                        rx_valid,
  input  logic [7:0]                  rx_op_code,
  input  roce_qp_pkg::qpn_t           rx_dest_qp,
  input  roce_qp_pkg::aeth_syndrome_t rx_syndrome,
  output logic                        cmd_valid,
  output roce_qp_pkg::qp_op_t         cmd_op,
  output roce_qp_pkg::qp_idx_t        cmd_idx,
  output roce_qp_pkg::qp_context_t    cmd_ctx,
  output roce_qp_pkg::aeth_syndrome_t cmd_syndrome
);

  logic                req_known;
  roce_qp_pkg::qp_op_t req_op;
  logic                fatal_nak;
  logic                issue_fatal;
  logic                issue_req;

  always_comb begin
    req_known = 1'b1;
    req_op    = roce_qp_pkg::OP_OPEN;
    case (qp_init_req_type)
      roce_qp_pkg::REQ_OPEN:       req_op = roce_qp_pkg::OP_OPEN;
      roce_qp_pkg::REQ_MODIFY_RTS: req_op = roce_qp_pkg::OP_TO_RTS;
      roce_qp_pkg::REQ_CLOSE:      req_op = roce_qp_pkg::OP_CLOSE;
      default:                     req_known = 1'b0;
    endcase
  end

  // NAK class 11 with a nonzero code, a PSN sequence NAK is not fatal
  assign fatal_nak = (rx_op_code == roce_qp_pkg::RC_ACK_OPCODE) &&
                     (rx_syndrome[6:5] == 2'b11) && (rx_syndrome[4:0] != 5'd0);

  assign issue_fatal = rx_valid && fatal_nak && roce_qp_pkg::qpn_in_range(rx_dest_qp);
  assign issue_req   = qp_init_valid && req_known &&
                       roce_qp_pkg::qpn_in_range(qp_init_loc_qpn);

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= issue_fatal || issue_req;
    end
  end

  // Fatal NAK wins, a host request in the same cycle is lost
  always_ff @(posedge clk) begin
    if (issue_fatal) begin
      cmd_op       <= roce_qp_pkg::OP_FATAL;
      cmd_idx      <= roce_qp_pkg::qpn_to_idx(rx_dest_qp);
      cmd_syndrome <= rx_syndrome;
    end else begin
      cmd_op       <= req_op;
      cmd_idx      <= roce_qp_pkg::qpn_to_idx(qp_init_loc_qpn);
      cmd_syndrome <= '0;
    end
    // Context as an OPEN stores it
    cmd_ctx.state       <= roce_qp_pkg::QP_INIT;
    cmd_ctx.rem_ip_addr <= qp_init_rem_ip_addr;
    cmd_ctx.rem_qpn     <= qp_init_rem_qpn;
    cmd_ctx.rem_psn     <= qp_init_rem_psn;
    cmd_ctx.loc_psn     <= qp_init_loc_psn;
    cmd_ctx.rem_addr    <= qp_init_rem_addr;
    cmd_ctx.r_key       <= qp_init_r_key;
    cmd_ctx.syndrome    <= '0;
  end

endmodule

// File: rtl/qp_context_store.sv
`timescale 1ns/1ps

module qp_context_store (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        cmd_valid,
  input  roce_qp_pkg::qp_op_t         cmd_op,
  input  roce_qp_pkg::qp_idx_t        cmd_idx,
  input  roce_qp_pkg::qp_context_t    cmd_ctx,
  input  roce_qp_pkg::aeth_syndrome_t cmd_syndrome,
  output logic                        qp_init_status_valid,
  output roce_qp_pkg::qp_status_t     qp_init_status,
  input  logic                        rd_valid,
  input  roce_qp_pkg::qpn_t           rd_qpn,
  output logic                        rd_ctx_valid,
  output roce_qp_pkg::qp_context_t    rd_ctx,
  output logic                        rd_error,
  output logic                        active,
  output roce_qp_pkg::qp_idx_t        active_idx,
  output logic                        activate,
  output roce_qp_pkg::psn_t           start_psn
);

  roce_qp_pkg::qp_context_t ctx_mem [roce_qp_pkg::QP_COUNT];
  roce_qp_pkg::qp_context_t cmd_cur;
  logic                     rd_in_range;

  assign cmd_cur     = ctx_mem[cmd_idx];
  assign rd_in_range = roce_qp_pkg::qpn_in_range(rd_qpn);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < roce_qp_pkg::QP_COUNT; i++) begin
        ctx_mem[i] <= '0;
      end
      active               <= 1'b0;
      active_idx           <= '0;
      activate             <= 1'b0;
      start_psn            <= '0;
      qp_init_status_valid <= 1'b0;
      qp_init_status       <= roce_qp_pkg::STATUS_OK;
    end else begin
      activate             <= 1'b0;
      qp_init_status_valid <= 1'b0;
      if (cmd_valid) begin
        case (cmd_op)
          roce_qp_pkg::OP_OPEN: begin
            qp_init_status_valid <= 1'b1;
            if (cmd_cur.state == roce_qp_pkg::QP_RESET) begin
              ctx_mem[cmd_idx] <= cmd_ctx;
              qp_init_status   <= roce_qp_pkg::STATUS_OK;
            end else begin
              qp_init_status <= roce_qp_pkg::STATUS_REFUSED;
            end
          end
          roce_qp_pkg::OP_TO_RTS: begin
            qp_init_status_valid <= 1'b1;
            // Only one QP may send at a time
            if (cmd_cur.state == roce_qp_pkg::QP_INIT && !active) begin
              ctx_mem[cmd_idx].state <= roce_qp_pkg::QP_RTS;
              active                 <= 1'b1;
              active_idx             <= cmd_idx;
              activate               <= 1'b1;
              start_psn              <= cmd_cur.rem_psn;
              qp_init_status         <= roce_qp_pkg::STATUS_OK;
            end else begin
              qp_init_status <= roce_qp_pkg::STATUS_REFUSED;
            end
          end
          roce_qp_pkg::OP_CLOSE: begin
            qp_init_status_valid <= 1'b1;
            if (cmd_cur.state != roce_qp_pkg::QP_RESET) begin
              ctx_mem[cmd_idx].state    <= roce_qp_pkg::QP_RESET;
              ctx_mem[cmd_idx].syndrome <= '0;
              qp_init_status            <= roce_qp_pkg::STATUS_OK;
              if (active && active_idx == cmd_idx) begin
                active <= 1'b0;
              end
            end else begin
              qp_init_status <= roce_qp_pkg::STATUS_REFUSED;
            end
          end
          default: begin
            // Fatal NAK, no status back to the host
            ctx_mem[cmd_idx].state    <= roce_qp_pkg::QP_ERROR;
            ctx_mem[cmd_idx].syndrome <= cmd_syndrome;
          end
        endcase
      end
    end
  end

  // Read stage one
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ctx_valid <= 1'b0;
      rd_error     <= 1'b0;
    end else begin
      rd_ctx_valid <= rd_valid && rd_in_range;
      rd_error     <= rd_valid && !rd_in_range;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid) begin
      rd_ctx <= ctx_mem[roce_qp_pkg::qpn_to_idx(rd_qpn)];
    end
  end

endmodule

// File: rtl/qp_read_delay.sv
`timescale 1ns/1ps

module qp_read_delay #(
  parameter type data_t = logic
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  in_valid,
  input  data_t in_data,
  output logic  out_valid,
  output data_t out_data
);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // Payload only moves with a valid beat
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_data <= in_data;
    end
  end

endmodule

// File: rtl/roce_qp_pkg.sv
package roce_qp_pkg;

  localparam int QP_COUNT = 4;
  localparam int QP_IDX_W = $clog2(QP_COUNT);

  typedef logic [23:0] qpn_t;
  typedef logic [23:0] psn_t;
  typedef logic [QP_IDX_W-1:0] qp_idx_t;
  typedef logic [7:0] aeth_syndrome_t;

  // Local QPNs run from QP_BASE up
  localparam qpn_t QP_BASE = 24'd256;

  typedef enum logic [2:0] {
    QP_RESET    = 3'd0,
    QP_INIT     = 3'd1,
    QP_RTR      = 3'd2,
    QP_RTS      = 3'd3,
    QP_SQ_DRAIN = 3'd4,
    QP_SQ_ERROR = 3'd5,
    QP_ERROR    = 3'd6
  } qp_state_t;

  // Host request codes, other values are ignored
  typedef logic [2:0] qp_req_t;
  localparam qp_req_t REQ_OPEN       = 3'd1;
  localparam qp_req_t REQ_MODIFY_RTS = 3'd2;
  localparam qp_req_t REQ_CLOSE      = 3'd3;

  typedef logic [1:0] qp_status_t;
  localparam qp_status_t STATUS_OK      = 2'd0;
  localparam qp_status_t STATUS_REFUSED = 2'd2;

  typedef enum logic [1:0] {
    OP_OPEN,
    OP_TO_RTS,
    OP_CLOSE,
    OP_FATAL
  } qp_op_t;

  localparam logic [7:0] RC_ACK_OPCODE = 8'h11;

  typedef struct packed {
    qp_state_t      state;
    logic [31:0]    rem_ip_addr;
    qpn_t           rem_qpn;
    psn_t           rem_psn;
    psn_t           loc_psn;
    logic [63:0]    rem_addr;
    logic [31:0]    r_key;
    aeth_syndrome_t syndrome;
  } qp_context_t;

  function automatic logic qpn_in_range(qpn_t qpn);
    return (qpn >= QP_BASE) && (qpn < QP_BASE + QP_COUNT);
  endfunction

  // Valid only for in-range QPNs
  function automatic qp_idx_t qpn_to_idx(qpn_t qpn);
    return qp_idx_t'(qpn - QP_BASE);
  endfunction

endpackage

// File: rtl/roce_qp_top.sv
`timescale 1ns/1ps

module roce_qp_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        qp_init_valid,
  input  roce_qp_pkg::qp_req_t        qp_init_req_type,
  input  logic [31:0]                 qp_init_r_key,
  input  roce_qp_pkg::qpn_t           qp_init_rem_qpn,
  input  roce_qp_pkg::qpn_t           qp_init_loc_qpn,
  input  roce_qp_pkg::psn_t           qp_init_rem_psn,
  input  roce_qp_pkg::psn_t           qp_init_loc_psn,
  input  logic [31:0]                 qp_init_rem_ip_addr,
  input  logic [63:0]                 qp_init_rem_addr,
  output logic                        qp_init_status_valid,
  output roce_qp_pkg::qp_status_t     qp_init_status,
  input  logic                        qp_context_req,
  input  roce_qp_pkg::qpn_t           qp_local_qpn_req,
  output logic                        qp_req_context_valid,
  output logic                        qp_req_error,
  output roce_qp_pkg::qp_state_t      qp_req_state,
  output logic [31:0]                 qp_req_r_key,
  output roce_qp_pkg::qpn_t           qp_req_rem_qpn,
  output roce_qp_pkg::qpn_t           qp_req_loc_qpn,
  output roce_qp_pkg::psn_t           qp_req_rem_psn,
  output roce_qp_pkg::psn_t           qp_req_loc_psn,
  output logic [31:0]                 qp_req_rem_ip_addr,
  output logic [63:0]                 qp_req_rem_addr,
  output roce_qp_pkg::aeth_syndrome_t qp_req_syndrome,
  output roce_qp_pkg::psn_t           qp_req_acked_psn,
  input  logic                        rx_bth_valid,
  input  logic [7:0]                  rx_bth_op_code,
  input  roce_qp_pkg::psn_t           rx_bth_psn,
  input  roce_qp_pkg::qpn_t           rx_bth_dest_qp,
  input  logic                        rx_aeth_valid,
  input  roce_qp_pkg::aeth_syndrome_t rx_aeth_syndrome,
  output roce_qp_pkg::psn_t           last_acked_psn,
  output roce_qp_pkg::psn_t           last_nacked_psn,
  output logic                        stop_transfer
);

  // Read result carried through the second stage
  typedef struct packed {
    logic                     error;
    roce_qp_pkg::qp_idx_t     idx;
    roce_qp_pkg::qp_context_t ctx;
  } rd_word_t;

  logic                        rx_valid;
  logic                        cmd_valid;
  roce_qp_pkg::qp_op_t         cmd_op;
  roce_qp_pkg::qp_idx_t        cmd_idx;
  roce_qp_pkg::qp_context_t    cmd_ctx;
  roce_qp_pkg::aeth_syndrome_t cmd_syndrome;
  logic                        active;
  roce_qp_pkg::qp_idx_t        active_idx;
  logic                        activate;
  roce_qp_pkg::psn_t           start_psn;
  logic                        rd_ctx_valid;
  logic                        rd_error;
  roce_qp_pkg::qp_context_t    rd_ctx;
  roce_qp_pkg::qp_idx_t        rd_idx_q;
  roce_qp_pkg::psn_t           rd_acked_psn;
  logic                        rd_word_valid;
  rd_word_t                    rd_word;
  logic                        acked_valid;
  roce_qp_pkg::psn_t           acked_psn_q;

  assign rx_valid = rx_bth_valid && rx_aeth_valid;

  qp_cmd_decode cmd_decode_i (
    .clk                 (clk),
    .rst                 (rst),
    .qp_init_valid       (qp_init_valid),
    .qp_init_req_type    (qp_init_req_type),
    .qp_init_loc_qpn     (qp_init_loc_qpn),
    .qp_init_r_key       (qp_init_r_key),
    .qp_init_rem_qpn     (qp_init_rem_qpn),
    .qp_init_rem_psn     (qp_init_rem_psn),
    .qp_init_loc_psn     (qp_init_loc_psn),
    .qp_init_rem_ip_addr (qp_init_rem_ip_addr),
    .qp_init_rem_addr    (qp_init_rem_addr),
    .rx_valid            (rx_valid),
    .rx_op_code          (rx_bth_op_code),
    .rx_dest_qp          (rx_bth_dest_qp),
    .rx_syndrome         (rx_aeth_syndrome),
    .cmd_valid           (cmd_valid),
    .cmd_op              (cmd_op),
    .cmd_idx             (cmd_idx),
    .cmd_ctx             (cmd_ctx),
    .cmd_syndrome        (cmd_syndrome)
  );

  qp_context_store context_store_i (
    .clk                  (clk),
    .rst                  (rst),
    .cmd_valid            (cmd_valid),
    .cmd_op               (cmd_op),
    .cmd_idx              (cmd_idx),
    .cmd_ctx              (cmd_ctx),
    .cmd_syndrome         (cmd_syndrome),
    .qp_init_status_valid (qp_init_status_valid),
    .qp_init_status       (qp_init_status),
    .rd_valid             (qp_context_req),
    .rd_qpn               (qp_local_qpn_req),
    .rd_ctx_valid         (rd_ctx_valid),
    .rd_ctx               (rd_ctx),
    .rd_error             (rd_error),
    .active               (active),
    .active_idx           (active_idx),
    .activate             (activate),
    .start_psn            (start_psn)
  );

  qp_ack_tracker ack_tracker_i (
    .clk             (clk),
    .rst             (rst),
    .rx_valid        (rx_valid),
    .rx_op_code      (rx_bth_op_code),
    .rx_dest_qp      (rx_bth_dest_qp),
    .rx_psn          (rx_bth_psn),
    .rx_syndrome     (rx_aeth_syndrome),
    .active          (active),
    .active_idx      (active_idx),
    .activate        (activate),
    .start_psn       (start_psn),
    .rd_valid        (qp_context_req),
    .rd_idx          (roce_qp_pkg::qpn_to_idx(qp_local_qpn_req)),
    .rd_acked_psn    (rd_acked_psn),
    .last_acked_psn  (last_acked_psn),
    .last_nacked_psn (last_nacked_psn),
    .stop_transfer   (stop_transfer)
  );

  // Index of the read in stage one, for the local QPN
  always_ff @(posedge clk) begin
    rd_idx_q <= roce_qp_pkg::qpn_to_idx(qp_local_qpn_req);
  end

  qp_read_delay #(.data_t(rd_word_t)) ctx_delay_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (rd_ctx_valid || rd_error),
    .in_data   ({rd_error, rd_idx_q, rd_ctx}),
    .out_valid (rd_word_valid),
    .out_data  (rd_word)
  );

  qp_read_delay #(.data_t(roce_qp_pkg::psn_t)) psn_delay_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (rd_ctx_valid),
    .in_data   (rd_acked_psn),
    .out_valid (acked_valid),
    .out_data  (acked_psn_q)
  );

  assign qp_req_context_valid = rd_word_valid && !rd_word.error;
  assign qp_req_error         = rd_word_valid && rd_word.error;
  assign qp_req_state         = rd_word.ctx.state;
  assign qp_req_r_key         = rd_word.ctx.r_key;
  assign qp_req_rem_qpn       = rd_word.ctx.rem_qpn;
  assign qp_req_loc_qpn       = roce_qp_pkg::QP_BASE + roce_qp_pkg::qpn_t'(rd_word.idx);
  assign qp_req_rem_psn       = rd_word.ctx.rem_psn;
  assign qp_req_loc_psn       = rd_word.ctx.loc_psn;
  assign qp_req_rem_ip_addr   = rd_word.ctx.rem_ip_addr;
  assign qp_req_rem_addr      = rd_word.ctx.rem_addr;
  assign qp_req_syndrome      = rd_word.ctx.syndrome;
  assign qp_req_acked_psn     = acked_valid ? acked_psn_q : '0;

endmodule

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module roce_qp_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vroce_qp_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

// File: tb/roce_qp_tb_table.svh
`ifndef ROCE_QP_TB_TABLE_SVH
`define ROCE_QP_TB_TABLE_SVH

typedef enum logic [1:0] {
  ROW_REQ,
  ROW_READ,
  ROW_RX
} row_kind_t;

// One step of the sequence and what it should return
typedef struct packed {
  row_kind_t                   kind;
  roce_qp_pkg::qp_req_t        req;
  roce_qp_pkg::qpn_t           qpn;
  roce_qp_pkg::psn_t           psn;
  roce_qp_pkg::aeth_syndrome_t syn;
  logic                        exp_resp;
  roce_qp_pkg::qp_status_t     exp_status;
  roce_qp_pkg::qp_state_t      exp_state;
  roce_qp_pkg::aeth_syndrome_t exp_syn;
  logic                        chk_track;
  roce_qp_pkg::psn_t           exp_acked;
  roce_qp_pkg::psn_t           exp_nacked;
  logic                        exp_stop;
} row_t;

row_t rows [$];

// exp_resp set means a status comes back
function automatic void add_req(roce_qp_pkg::qp_req_t req, roce_qp_pkg::qpn_t qpn,
                                roce_qp_pkg::psn_t psn, logic resp,
                                roce_qp_pkg::qp_status_t status);
  row_t r;
  r            = '0;
  r.kind       = ROW_REQ;
  r.req        = req;
  r.qpn        = qpn;
  r.psn        = psn;
  r.exp_resp   = resp;
  r.exp_status = status;
  rows.push_back(r);
endfunction

// Tracker outputs one cycle after the status of the previous request
function automatic void add_track(roce_qp_pkg::psn_t acked, roce_qp_pkg::psn_t nacked,
                                  logic stop);
  row_t r;
  r            = rows.pop_back();
  r.chk_track  = 1'b1;
  r.exp_acked  = acked;
  r.exp_nacked = nacked;
  r.exp_stop   = stop;
  rows.push_back(r);
endfunction

// exp_resp set means context valid, clear means error strobe
function automatic void add_read(roce_qp_pkg::qpn_t qpn, logic resp,
                                 roce_qp_pkg::qp_state_t state,
                                 roce_qp_pkg::aeth_syndrome_t syn, roce_qp_pkg::psn_t acked);
  row_t r;
  r           = '0;
  r.kind      = ROW_READ;
  r.qpn       = qpn;
  r.exp_resp  = resp;
  r.exp_state = state;
  r.exp_syn   = syn;
  r.exp_acked = acked;
  rows.push_back(r);
endfunction

function automatic void add_rx(roce_qp_pkg::qpn_t qpn, roce_qp_pkg::psn_t psn,
                               roce_qp_pkg::aeth_syndrome_t syn, roce_qp_pkg::psn_t acked,
                               roce_qp_pkg::psn_t nacked, logic stop);
  row_t r;
  r            = '0;
  r.kind       = ROW_RX;
  r.qpn        = qpn;
  r.psn        = psn;
  r.syn        = syn;
  r.chk_track  = 1'b1;
  r.exp_acked  = acked;
  r.exp_nacked = nacked;
  r.exp_stop   = stop;
  rows.push_back(r);
endfunction

function automatic void build_table();
  // Open and read back
  add_req(roce_qp_pkg::REQ_OPEN, 24'd256, 24'h001000, 1'b1, roce_qp_pkg::STATUS_OK);
  add_read(24'd256, 1'b1, roce_qp_pkg::QP_INIT, 8'h00, 24'h000000);
  add_req(roce_qp_pkg::REQ_OPEN, 24'd256, 24'h001000, 1'b1, roce_qp_pkg::STATUS_REFUSED);
  // Single RTS rule
  add_req(roce_qp_pkg::REQ_MODIFY_RTS, 24'd256, 24'h0, 1'b1, roce_qp_pkg::STATUS_OK);
  add_track(24'h001000, 24'h001000, 1'b0);
  add_req(roce_qp_pkg::REQ_OPEN, 24'd257, 24'h002000, 1'b1, roce_qp_pkg::STATUS_OK);
  add_req(roce_qp_pkg::REQ_MODIFY_RTS, 24'd257, 24'h0, 1'b1, roce_qp_pkg::STATUS_REFUSED);
  add_req(roce_qp_pkg::REQ_MODIFY_RTS, 24'd258, 24'h0, 1'b1, roce_qp_pkg::STATUS_REFUSED);
  // Good ACK, then a NAK that is not fatal
  add_rx(24'd256, 24'h001005, 8'h00, 24'h001005, 24'h001000, 1'b0);
  add_read(24'd256, 1'b1, roce_qp_pkg::QP_RTS, 8'h00, 24'h001005);
  add_rx(24'd256, 24'h001006, 8'h60, 24'h001005, 24'h001006, 1'b1);
  // Fatal NAK to an idle QP
  add_rx(24'd257, 24'h002001, 8'h61, 24'h001005, 24'h001006, 1'b0);
  add_read(24'd257, 1'b1, roce_qp_pkg::QP_ERROR, 8'h61, 24'h000000);
  // Close
  add_req(roce_qp_pkg::REQ_CLOSE, 24'd256, 24'h0, 1'b1, roce_qp_pkg::STATUS_OK);
  add_read(24'd256, 1'b1, roce_qp_pkg::QP_RESET, 8'h00, 24'h001005);
  add_req(roce_qp_pkg::REQ_CLOSE, 24'd256, 24'h0, 1'b1, roce_qp_pkg::STATUS_REFUSED);
  add_req(roce_qp_pkg::REQ_MODIFY_RTS, 24'd257, 24'h0, 1'b1, roce_qp_pkg::STATUS_REFUSED);
  // Out of range QPN
  add_read(24'd300, 1'b0, roce_qp_pkg::QP_RESET, 8'h00, 24'h000000);
  add_req(roce_qp_pkg::REQ_OPEN, 24'd300, 24'h003000, 1'b0, roce_qp_pkg::STATUS_OK);
endfunction

`endif

// File: tb/roce_qp_tb.sv
`timescale 1ns/1ps

module roce_qp_tb;

  localparam int TIMEOUT_CYCLES = 10;
  localparam int RESP_LATENCY   = 2;

  logic                        clk;
  logic                        rst;
  logic                        qp_init_valid;
  roce_qp_pkg::qp_req_t        qp_init_req_type;
  logic [31:0]                 qp_init_r_key;
  roce_qp_pkg::qpn_t           qp_init_rem_qpn;
  roce_qp_pkg::qpn_t           qp_init_loc_qpn;
  roce_qp_pkg::psn_t           qp_init_rem_psn;
  roce_qp_pkg::psn_t           qp_init_loc_psn;
  logic [31:0]                 qp_init_rem_ip_addr;
  logic [63:0]                 qp_init_rem_addr;
  logic                        qp_init_status_valid;
  roce_qp_pkg::qp_status_t     qp_init_status;
  logic                        qp_context_req;
  roce_qp_pkg::qpn_t           qp_local_qpn_req;
  logic                        qp_req_context_valid;
  logic                        qp_req_error;
  roce_qp_pkg::qp_state_t      qp_req_state;
  logic [31:0]                 qp_req_r_key;
  roce_qp_pkg::qpn_t           qp_req_rem_qpn;
  roce_qp_pkg::qpn_t           qp_req_loc_qpn;
  roce_qp_pkg::psn_t           qp_req_rem_psn;
  roce_qp_pkg::psn_t           qp_req_loc_psn;
  logic [31:0]                 qp_req_rem_ip_addr;
  logic [63:0]                 qp_req_rem_addr;
  roce_qp_pkg::aeth_syndrome_t qp_req_syndrome;
  roce_qp_pkg::psn_t           qp_req_acked_psn;
  logic                        rx_bth_valid;
  logic [7:0]                  rx_bth_op_code;
  roce_qp_pkg::psn_t           rx_bth_psn;
  roce_qp_pkg::qpn_t           rx_bth_dest_qp;
  logic                        rx_aeth_valid;
  roce_qp_pkg::aeth_syndrome_t rx_aeth_syndrome;
  roce_qp_pkg::psn_t           last_acked_psn;
  roce_qp_pkg::psn_t           last_nacked_psn;
  logic                        stop_transfer;

  // Fields each QP was opened with
  roce_qp_pkg::qp_context_t opened_ctx [roce_qp_pkg::qpn_t];
  logic [15:0]              lfsr_state;

  `include "roce_qp_tb_table.svh"

  roce_qp_top roce_qp_top_i (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] lfsr_bits(int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return bits;
  endfunction

  function automatic roce_qp_pkg::qp_context_t make_open_ctx(roce_qp_pkg::qpn_t qpn,
                                                             roce_qp_pkg::psn_t psn);
    roce_qp_pkg::qp_context_t ctx;
    ctx.state       = roce_qp_pkg::QP_INIT;
    ctx.rem_ip_addr = {8'h0a, qpn};
    ctx.rem_qpn     = qpn + 24'h000100;
    ctx.rem_psn     = psn;
    ctx.loc_psn     = ~psn;
    ctx.r_key       = lfsr_bits(32);
    ctx.rem_addr    = {lfsr_bits(32), lfsr_bits(32)};
    ctx.syndrome    = '0;
    return ctx;
  endfunction

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_status(string what, roce_qp_pkg::qp_status_t got,
                              roce_qp_pkg::qp_status_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0d ns: %s status %0d, expected %0d",
                         $time, what, got, exp));
    end
  endtask

  task automatic check_ctx(string what, roce_qp_pkg::qp_context_t got,
                           roce_qp_pkg::qp_context_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0d ns: %s context %h, expected %h",
                         $time, what, got, exp));
    end
  endtask

  task automatic check_qpn(string what, roce_qp_pkg::qpn_t got, roce_qp_pkg::qpn_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0d ns: %s %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_psn(string what, roce_qp_pkg::psn_t got, roce_qp_pkg::psn_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0d ns: %s %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(string what, logic got, logic exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0d ns: %s %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_latency(string what, int got, int exp);
    if (got != exp) begin
      fail_run($sformatf("mismatch at %0d ns: %s after %0d cycles, expected %0d",
                         $time, what, got, exp));
    end
  endtask

  // One clock, then inputs change 1 ns past the edge
  task automatic step();
    @(posedge clk);
    #1;
    qp_init_valid  = 1'b0;
    qp_context_req = 1'b0;
    rx_bth_valid   = 1'b0;
    rx_aeth_valid  = 1'b0;
  endtask

  task automatic check_tracker(row_t r);
    check_psn("last_acked_psn", last_acked_psn, r.exp_acked);
    check_psn("last_nacked_psn", last_nacked_psn, r.exp_nacked);
    check_flag("stop_transfer", stop_transfer, r.exp_stop);
  endtask

  task automatic run_req(row_t r);
    roce_qp_pkg::qp_context_t ctx;
    int                       cycles;
    ctx                 = make_open_ctx(r.qpn, r.psn);
    qp_init_valid       = 1'b1;
    qp_init_req_type    = r.req;
    qp_init_loc_qpn     = r.qpn;
    qp_init_rem_qpn     = ctx.rem_qpn;
    qp_init_rem_psn     = ctx.rem_psn;
    qp_init_loc_psn     = ctx.loc_psn;
    qp_init_rem_ip_addr = ctx.rem_ip_addr;
    qp_init_rem_addr    = ctx.rem_addr;
    qp_init_r_key       = ctx.r_key;
    step();
    cycles = 1;
    while (!qp_init_status_valid && cycles < TIMEOUT_CYCLES) begin
      step();
      cycles++;
    end
    if (!r.exp_resp) begin
      if (qp_init_status_valid) begin
        fail_run($sformatf("a status came back for dropped request to QPN %0d", r.qpn));
      end
    end else begin
      if (!qp_init_status_valid) begin
        fail_run($sformatf("no status within %0d cycles for QPN %0d", cycles, r.qpn));
      end
      check_latency("request status", cycles, RESP_LATENCY);
      check_status($sformatf("QPN %0d", r.qpn), qp_init_status, r.exp_status);
      if (r.req == roce_qp_pkg::REQ_OPEN && r.exp_status == roce_qp_pkg::STATUS_OK) begin
        opened_ctx[r.qpn] = ctx;
      end
      if (r.chk_track) begin
        step();
        check_tracker(r);
      end
    end
  endtask

  task automatic run_read(row_t r);
    roce_qp_pkg::qp_context_t got;
    roce_qp_pkg::qp_context_t exp;
    int                       cycles;
    qp_context_req   = 1'b1;
    qp_local_qpn_req = r.qpn;
    step();
    cycles = 1;
    while (!(qp_req_context_valid || qp_req_error) && cycles < TIMEOUT_CYCLES) begin
      step();
      cycles++;
    end
    if (!(qp_req_context_valid || qp_req_error)) begin
      fail_run($sformatf("no read result within %0d cycles for QPN %0d", cycles, r.qpn));
    end
    check_latency("read result", cycles, RESP_LATENCY);
    check_flag("qp_req_context_valid", qp_req_context_valid, r.exp_resp);
    check_flag("qp_req_error", qp_req_error, !r.exp_resp);
    if (r.exp_resp) begin
      exp             = opened_ctx[r.qpn];
      exp.state       = r.exp_state;
      exp.syndrome    = r.exp_syn;
      got.state       = qp_req_state;
      got.rem_ip_addr = qp_req_rem_ip_addr;
      got.rem_qpn     = qp_req_rem_qpn;
      got.rem_psn     = qp_req_rem_psn;
      got.loc_psn     = qp_req_loc_psn;
      got.rem_addr    = qp_req_rem_addr;
      got.r_key       = qp_req_r_key;
      got.syndrome    = qp_req_syndrome;
      check_ctx($sformatf("QPN %0d", r.qpn), got, exp);
      check_qpn("qp_req_loc_qpn", qp_req_loc_qpn, r.qpn);
      check_psn("qp_req_acked_psn", qp_req_acked_psn, r.exp_acked);
    end
  endtask

  task automatic run_rx(row_t r);
    rx_bth_valid     = 1'b1;
    rx_aeth_valid    = 1'b1;
    rx_bth_op_code   = roce_qp_pkg::RC_ACK_OPCODE;
    rx_bth_dest_qp   = r.qpn;
    rx_bth_psn       = r.psn;
    rx_aeth_syndrome = r.syn;
    // Tracker registers follow one edge later
    step();
    check_tracker(r);
  endtask

  initial begin
    clk                 = 1'b0;
    rst                 = 1'b1;
    lfsr_state          = 16'd47933;
    qp_init_valid       = 1'b0;
    qp_init_req_type    = '0;
    qp_init_r_key       = '0;
    qp_init_rem_qpn     = '0;
    qp_init_loc_qpn     = '0;
    qp_init_rem_psn     = '0;
    qp_init_loc_psn     = '0;
    qp_init_rem_ip_addr = '0;
    qp_init_rem_addr    = '0;
    qp_context_req      = 1'b0;
    qp_local_qpn_req    = '0;
    rx_bth_valid        = 1'b0;
    rx_bth_op_code      = '0;
    rx_bth_psn          = '0;
    rx_bth_dest_qp      = '0;
    rx_aeth_valid       = 1'b0;
    rx_aeth_syndrome    = '0;
    build_table();
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (rows[i]) begin
      case (rows[i].kind)
        ROW_REQ:  run_req(rows[i]);
        ROW_READ: run_read(rows[i]);
        default:  run_rx(rows[i]);
      endcase
      // Let a pending command commit before the next row
      step();
    end
    $display("TB PASSED");
    $finish;
  end

endmodule
